/* hw/spi_cmd_port.sv */
`timescale 1ns/100ps
`include "trs_io_consts.svh"

module spi_cmd_port (
  input  logic              clk,
  input  logic              reset,
  input  logic              sck,
  input  logic              mosi,
  input  logic              cs_n,
  output logic              miso,
  input  trs_io_pkg::byte_t trs_d_in,
  output logic              full_addr,
  output logic              dbus_load,
  output trs_io_pkg::byte_t dbus_byte,
  cmd_mem_if.cmd            mem
);

  logic [2:0]                 sck_q;
  logic [1:0]                 mosi_q;
  logic [2:0]                 cs_q;
  logic                       sck_rise, sck_fall;
  logic                       cs_active, cs_start;
  logic [2:0]                 bit_cnt;
  trs_io_pkg::byte_t          rx_sr;
  trs_io_pkg::byte_t          rx_byte;
  logic                       byte_done;
  logic                       cmd_byte;   // byte that goes to the parser
  trs_io_pkg::parse_state_e   state;
  trs_io_pkg::cmd_code_e      cmd;
  trs_io_pkg::byte_t          params [0:2];
  logic [1:0]                 param_idx;
  logic [1:0]                 param_left;
  logic                       act;        // all params in, run the command
  trs_io_pkg::trs_addr_t      cmd_addr;
  logic                       resp_load;
  trs_io_pkg::byte_t          resp_next;
  trs_io_pkg::byte_t          resp_byte;
  logic                       resp_pending;
  logic                       tx_active;
  trs_io_pkg::byte_t          tx_sr;

  always_ff @(posedge clk) begin
    if (reset) begin
      sck_q  <= 3'b000;
      mosi_q <= 2'b00;
      cs_q   <= 3'b111;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      mosi_q <= {mosi_q[0], mosi};
      cs_q   <= {cs_q[1:0], cs_n};
    end
  end

  assign sck_rise  = (sck_q[2:1] == 2'b01);
  assign sck_fall  = (sck_q[2:1] == 2'b10);
  assign cs_active = ~cs_q[1];
  assign cs_start  = (cs_q[2:1] == 2'b10);  // cs just went low

  assign rx_byte   = {rx_sr[6:0], mosi_q[1]};
  assign byte_done = cs_active & sck_rise & (bit_cnt == 3'd7);
  assign cmd_byte  = byte_done & ~tx_active; // response slot is not parsed

  always_ff @(posedge clk) begin
    if (reset || !cs_active)
      bit_cnt <= 3'd0;
    else if (sck_rise)
      bit_cnt <= bit_cnt + 3'd1;
  end

  always_ff @(posedge clk) begin
    if (sck_rise)
      rx_sr <= rx_byte;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= trs_io_pkg::idle;
      cmd        <= trs_io_pkg::get_cookie;
      param_idx  <= 2'd0;
      param_left <= 2'd0;
      act        <= 1'b0;
    end else begin
      act <= 1'b0;
      if (cs_start) begin
        state <= trs_io_pkg::idle;
      end else if (cmd_byte) begin
        case (state)
          trs_io_pkg::idle: begin
            cmd       <= trs_io_pkg::cmd_code_e'(rx_byte);
            param_idx <= 2'd0;
            case (trs_io_pkg::cmd_code_e'(rx_byte))
              trs_io_pkg::ram_poke: begin
                param_left <= 2'd3;   // addr lo, addr hi, data
                state      <= trs_io_pkg::read_params;
              end
              trs_io_pkg::ram_peek: begin
                param_left <= 2'd2;
                state      <= trs_io_pkg::read_params;
              end
              trs_io_pkg::dbus_write,
              trs_io_pkg::set_full_addr: begin
                param_left <= 2'd1;
                state      <= trs_io_pkg::read_params;
              end
              default: state <= trs_io_pkg::idle;  // answered right away or unknown
            endcase
          end
          trs_io_pkg::read_params: begin
            param_idx <= param_idx + 2'd1;
            if (param_left == 2'd1) begin
              act   <= 1'b1;
              state <= trs_io_pkg::idle;
            end else begin
              param_left <= param_left - 2'd1;
            end
          end
          default: state <= trs_io_pkg::idle;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_byte && state == trs_io_pkg::read_params)
      params[param_idx] <= rx_byte;
  end

  always_ff @(posedge clk) begin
    if (reset)
      full_addr <= 1'b0;
    else if (act && cmd == trs_io_pkg::set_full_addr)
      full_addr <= (params[0] != '0);
  end

  assign cmd_addr  = {params[1], params[0]};
  assign mem.addr  = cmd_addr[`RAM_ADDR_W-1:0];
  assign mem.wdata = params[2];
  assign mem.we    = (cmd == trs_io_pkg::ram_poke);
  assign mem.en    = act & ((cmd == trs_io_pkg::ram_poke) | (cmd == trs_io_pkg::ram_peek));
  assign dbus_load = act & (cmd == trs_io_pkg::dbus_write);
  assign dbus_byte = params[0];

  // pick the response byte
  always_comb begin
    resp_load = 1'b0;
    resp_next = mem.rdata;
    if (mem.rdata_valid) begin
      resp_load = 1'b1;   // peek result
    end else if (cmd_byte && state == trs_io_pkg::idle) begin
      case (trs_io_pkg::cmd_code_e'(rx_byte))
        trs_io_pkg::get_cookie: begin
          resp_load = 1'b1;
          resp_next = `COOKIE;
        end
        trs_io_pkg::get_version: begin
          resp_load = 1'b1;
          resp_next = {`VERSION_MAJOR, `VERSION_MINOR};
        end
        trs_io_pkg::dbus_read: begin
          resp_load = 1'b1;
          resp_next = trs_d_in;  // z80 is parked on wait
        end
        default: resp_load = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (resp_load)
      resp_byte <= resp_next;
  end

  // msb goes out at the byte boundary, rest on falling edges
  always_ff @(posedge clk) begin
    if (reset || cs_start) begin
      resp_pending <= 1'b0;
      tx_active    <= 1'b0;
      tx_sr        <= '0;
    end else begin
      if (resp_load)
        resp_pending <= 1'b1;
      if (cs_active && sck_fall) begin
        if (bit_cnt == 3'd0 && resp_pending) begin
          tx_sr        <= resp_byte;
          resp_pending <= 1'b0;
          tx_active    <= 1'b1;
        end else begin
          tx_sr <= {tx_sr[6:0], 1'b0};
        end
      end
      if (byte_done && tx_active)
        tx_active <= 1'b0;  // response byte fully clocked
    end
  end

  assign miso = cs_active ? tx_sr[7] : 1'b0;

  a_en_after_params: assert property (@(posedge clk) disable iff (reset)
    mem.en |-> state == trs_io_pkg::idle)
    else $error("ram en while parameters still pending");

endmodule

/* hw/trs_bus_decoder.sv */
`timescale 1ns/100ps
`include "trs_io_consts.svh"

module trs_bus_decoder (
  input  logic                    clk,
  input  logic                    reset,
  input  trs_io_pkg::byte_t       trs_ah,
  input  trs_io_pkg::byte_t       trs_d_in,
  input  logic                    rd_n,
  input  logic                    wr_n,
  input  logic                    in_n,
  input  logic                    out_n,
  input  logic                    esp_done,
  input  logic                    full_addr,
  output logic [1:0]              mux_a,
  output logic                    trs_oe,
  output logic                    trs_dir,
  output logic                    esp_req,
  output logic                    esp_wait,
  output trs_io_pkg::esp_status_e esp_s,
  bus_mem_if.decoder              mem
);

  localparam int CNT_W = $clog2(`ESP_REQ_CYCLES + 1);

  logic [3:0]            strb_meta;   // {rd, wr, in, out}, active low
  logic [3:0]            strb_sync;
  logic                  rd_s, wr_s, in_s, out_s;
  logic                  access;
  logic                  access_q;
  logic                  access_rise;
  logic [`TAP_ACCESS:0]  trig;        // access edge walking down the taps
  trs_io_pkg::trs_addr_t addr;
  logic                  addr_valid;
  logic                  ram_sel;
  logic                  port_sel;
  logic                  esp_start;
  logic [2:0]            done_sr;
  logic                  done_rise;
  logic [CNT_W-1:0]      req_cnt;

  // two flop sync of the four strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      strb_meta <= 4'hf;
      strb_sync <= 4'hf;
      access_q  <= 1'b0;
      trig      <= '0;
    end else begin
      strb_meta <= {rd_n, wr_n, in_n, out_n};
      strb_sync <= strb_meta;
      access_q  <= access;
      trig      <= {trig[`TAP_ACCESS-1:0], access_rise};
    end
  end

  assign {rd_s, wr_s, in_s, out_s} = strb_sync;
  assign access      = ~&strb_sync;          // any strobe low
  assign access_rise = access & ~access_q;

  // high byte on the mux while the edge is in the early stages
  assign mux_a = (trig[`TAP_HIGH:0] != '0) ? 2'b01 : 2'b10;

  always_ff @(posedge clk) begin
    if (trig[`TAP_HIGH]) begin
      // board swaps the high address lines
      addr[15:8] <= {trs_ah[5], trs_ah[4], trs_ah[7], trs_ah[6],
                     trs_ah[3], trs_ah[2], trs_ah[0], trs_ah[1]};
    end
    if (trig[`TAP_LOW]) begin
      addr[7:0] <= trs_ah;
      mem.wdata <= trs_d_in;  // write data already stable here
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      addr_valid <= 1'b0;
    else if (trig[`TAP_LOW])
      addr_valid <= 1'b1;
    else if (trig[`TAP_HIGH] || !access)
      addr_valid <= 1'b0;   // half captured, or the cycle is over
  end

  // upper 32k normally, upper 48k in full address mode
  assign ram_sel  = addr_valid & (full_addr ? (addr[15] | addr[14]) : addr[15]);
  assign port_sel = addr_valid & (addr[7:0] == `TRS_IO_PORT);

  assign mem.addr  = addr[`RAM_ADDR_W-1:0];
  assign mem.rd_en = trig[`TAP_ACCESS] & ram_sel & ~rd_s;
  assign mem.wr_en = trig[`TAP_ACCESS] & ram_sel & ~wr_s;
  assign esp_start = trig[`TAP_ACCESS] & port_sel & (~in_s | ~out_s);

  // bus buffer on while we own the cycle
  assign trs_oe  = ~((ram_sel & ~(rd_s & wr_s)) | (port_sel & ~(in_s & out_s)));
  assign trs_dir = rd_n & in_n;   // low drives toward the z80

  always_ff @(posedge clk) begin
    if (reset)
      done_sr <= 3'b000;
    else
      done_sr <= {done_sr[1:0], esp_done};
  end

  assign done_rise = (done_sr[2:1] == 2'b01);

  // request pulse and wait level for the coprocessor
  always_ff @(posedge clk) begin
    if (reset) begin
      esp_req  <= 1'b0;
      esp_wait <= 1'b0;
      req_cnt  <= '0;
      esp_s    <= trs_io_pkg::trs_io_in;
    end else if (esp_start) begin
      esp_req  <= 1'b1;   // restarts if already running
      esp_wait <= 1'b1;
      req_cnt  <= CNT_W'(`ESP_REQ_CYCLES);
      esp_s    <= !out_s ? trs_io_pkg::trs_io_out : trs_io_pkg::trs_io_in;
    end else begin
      if (done_rise)
        esp_wait <= 1'b0;
      if (req_cnt == CNT_W'(1))
        esp_req <= 1'b0;
      if (req_cnt != '0)
        req_cnt <= req_cnt - CNT_W'(1);
    end
  end

  a_one_ram_op: assert property (@(posedge clk) disable iff (reset)
    !(mem.rd_en && mem.wr_en))
    else $error("rd_en and wr_en high together");

  a_wait_with_req: assert property (@(posedge clk) disable iff (reset)
    $rose(esp_wait) |-> esp_req)
    else $error("esp_wait rose without esp_req");

endmodule

/* hw/trs_data_path.sv */
`timescale 1ns/100ps
`include "trs_io_consts.svh"

module trs_data_path (
  input  logic              clk,
  input  logic              reset,
  bus_mem_if.ram            bus,
  cmd_mem_if.ram            cmd,
  input  logic              dbus_load,
  input  trs_io_pkg::byte_t dbus_byte,
  output trs_io_pkg::byte_t trs_d_out
);

  trs_io_pkg::byte_t ram [0:(1 << `RAM_ADDR_W) - 1];
  trs_io_pkg::byte_t ram_a_q;   // bus port read data
  logic              bus_rd_q;  // ram_a_q valid next clock

  // port a, z80 side
  always @(posedge clk) begin
    if (bus.wr_en)
      ram[bus.addr] <= bus.wdata;
    if (bus.rd_en)
      ram_a_q <= ram[bus.addr];
  end

  // port b, coprocessor side
  always @(posedge clk) begin
    if (cmd.en) begin
      if (cmd.we)
        ram[cmd.addr] <= cmd.wdata;
      else
        cmd.rdata <= ram[cmd.addr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd.rdata_valid <= 1'b0;
      bus_rd_q        <= 1'b0;
    end else begin
      cmd.rdata_valid <= cmd.en & ~cmd.we;
      bus_rd_q        <= bus.rd_en;
    end
  end

  // byte the z80 sees on rd or in
  always_ff @(posedge clk) begin
    if (bus_rd_q)
      trs_d_out <= ram_a_q;
    else if (dbus_load)
      trs_d_out <= dbus_byte;   // answer for a port 31 in
  end

  a_valid_after_read: assert property (@(posedge clk) disable iff (reset)
    cmd.rdata_valid |-> $past(cmd.en && !cmd.we))
    else $error("rdata_valid without a read enable");

endmodule

/* hw/trs_io_bridge.sv */
`timescale 1ns/100ps

module trs_io_bridge (
  input  logic       clk,
  input  logic       reset,
  input  logic       sck,
  input  logic       mosi,
  input  logic       cs_n,
  output logic       miso,
  input  logic [7:0] trs_ah,
  input  logic [7:0] trs_d_in,
  output logic [7:0] trs_d_out,
  output logic       trs_dir,
  output logic       trs_oe,
  output logic [1:0] mux_a,
  input  logic       rd_n,
  input  logic       wr_n,
  input  logic       in_n,
  input  logic       out_n,
  input  logic       esp_done,
  output logic       esp_req,
  output logic       esp_wait,
  output logic [2:0] esp_s
);

  logic       full_addr;
  logic       dbus_load;
  logic [7:0] dbus_byte;

  bus_mem_if bus_mem ();
  cmd_mem_if cmd_mem ();

  trs_bus_decoder u_decoder (
    .clk       (clk),
    .reset     (reset),
    .trs_ah    (trs_ah),
    .trs_d_in  (trs_d_in),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .in_n      (in_n),
    .out_n     (out_n),
    .esp_done  (esp_done),
    .full_addr (full_addr),
    .mux_a     (mux_a),
    .trs_oe    (trs_oe),
    .trs_dir   (trs_dir),
    .esp_req   (esp_req),
    .esp_wait  (esp_wait),
    .esp_s     (esp_s),
    .mem       (bus_mem.decoder)
  );

  spi_cmd_port u_spi (
    .clk       (clk),
    .reset     (reset),
    .sck       (sck),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .miso      (miso),
    .trs_d_in  (trs_d_in),
    .full_addr (full_addr),
    .dbus_load (dbus_load),
    .dbus_byte (dbus_byte),
    .mem       (cmd_mem.cmd)
  );

  trs_data_path u_data (
    .clk       (clk),
    .reset     (reset),
    .bus       (bus_mem.ram),
    .cmd       (cmd_mem.ram),
    .dbus_load (dbus_load),
    .dbus_byte (dbus_byte),
    .trs_d_out (trs_d_out)
  );

endmodule

/* hw/trs_io_consts.svh */
`ifndef TRS_IO_CONSTS_SVH
`define TRS_IO_CONSTS_SVH

// magic byte answered to get cookie
`define COOKIE 8'haf

// version byte is {major, minor}
`define VERSION_MAJOR 3'd0
`define VERSION_MINOR 5'd3

// z80 i/o port served by the coprocessor
`define TRS_IO_PORT 8'd31

// length of the esp_req pulse in clocks
`define ESP_REQ_CYCLES 50

// on-chip ram is 2**RAM_ADDR_W bytes
`define RAM_ADDR_W 15

// stages of the access shift register
`define TAP_HIGH 3
`define TAP_LOW 7
`define TAP_ACCESS 8

`endif

/* hw/trs_io_ifs.sv */
`timescale 1ns/100ps

// bus side ram port, driven by the address decoder
interface bus_mem_if;
  trs_io_pkg::ram_addr_t addr;
  logic                  rd_en;  // one clock
  logic                  wr_en;  // one clock
  trs_io_pkg::byte_t     wdata;  // latched z80 data

  modport decoder (
    output addr, rd_en, wr_en, wdata
  );
  modport ram (
    input addr, rd_en, wr_en, wdata
  );
endinterface

// command side ram port, driven by the spi parser
interface cmd_mem_if;
  trs_io_pkg::ram_addr_t addr;
  trs_io_pkg::byte_t     wdata;
  logic                  we;
  logic                  en;          // one clock
  trs_io_pkg::byte_t     rdata;
  logic                  rdata_valid; // clock after a read en

  modport cmd (
    output addr, wdata, we, en,
    input  rdata, rdata_valid
  );
  modport ram (
    input  addr, wdata, we, en,
    output rdata, rdata_valid
  );
endinterface

/* hw/trs_io_pkg.sv */
`include "trs_io_consts.svh"

package trs_io_pkg;

  typedef logic [7:0]             byte_t;     // bus or spi byte
  typedef logic [15:0]            trs_addr_t; // full z80 address
  typedef logic [`RAM_ADDR_W-1:0] ram_addr_t; // word address into ram

  // command byte sent by the coprocessor
  typedef enum logic [7:0] {
    get_cookie    = 8'd0,
    ram_poke      = 8'd1,
    ram_peek      = 8'd2,
    dbus_read     = 8'd3,
    dbus_write    = 8'd4,
    set_full_addr = 8'd14,
    get_version   = 8'd15
  } cmd_code_e;

  typedef enum logic {
    idle,        // waiting for a command byte
    read_params  // collecting parameter bytes
  } parse_state_e;

  // what the coprocessor is asked to do, on esp_s
  typedef enum logic [2:0] {
    trs_io_in  = 3'd0,
    trs_io_out = 3'd1
  } esp_status_e;

endpackage

/* tests/trs_io_bridge_tb.sv */
`timescale 1ns/100ps
`include "trs_io_consts.svh"

module trs_io_bridge_tb;

  localparam int BUS_RD  = 0;
  localparam int BUS_WR  = 1;
  localparam int BUS_IN  = 2;
  localparam int BUS_OUT = 3;

  logic        clk;
  logic        reset;
  logic        sck;
  logic        mosi;
  logic        cs_n;
  logic        miso;
  logic [7:0]  trs_ah;
  logic [7:0]  trs_d_in;
  logic [7:0]  trs_d_out;
  logic        trs_dir;
  logic        trs_oe;
  logic [1:0]  mux_a;
  logic        rd_n;
  logic        wr_n;
  logic        in_n;
  logic        out_n;
  logic        esp_done;
  logic        esp_req;
  logic        esp_wait;
  logic [2:0]  esp_s;

  logic [15:0] bus_addr;   // address the z80 puts out
  logic        oe_min;     // lowest trs_oe seen in the bus cycle
  logic [31:0] lcg_state;
  int          checks;
  int          errors;
  int          timeouts;

  trs_io_bridge UUT (
    .clk       (clk),
    .reset     (reset),
    .sck       (sck),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .miso      (miso),
    .trs_ah    (trs_ah),
    .trs_d_in  (trs_d_in),
    .trs_d_out (trs_d_out),
    .trs_dir   (trs_dir),
    .trs_oe    (trs_oe),
    .mux_a     (mux_a),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .in_n      (in_n),
    .out_n     (out_n),
    .esp_done  (esp_done),
    .esp_req   (esp_req),
    .esp_wait  (esp_wait),
    .esp_s     (esp_s)
  );

  // board wiring of the high address lines
  function automatic logic [7:0] board_scramble(input logic [7:0] h);
    return {h[5], h[4], h[7], h[6], h[3], h[2], h[0], h[1]};
  endfunction

  // external address mux, high byte on 01
  assign trs_ah = (mux_a == 2'b01) ? board_scramble(bus_addr[15:8]) : bus_addr[7:0];

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp)
    else begin
      errors++;
      $display("error %s expected 0x%0h got 0x%0h", name, exp, got);
    end
  endtask

  task report_timeout(input string what);
    timeouts++;
    $display("timed out waiting for %s", what);
  endtask

  // z80 side, every task starts and ends on a falling edge
  task bus_start(input int kind, input logic [15:0] addr, input logic [7:0] data);
    bus_addr = addr;
    trs_d_in = data;
    oe_min   = 1'b1;
    rd_n     = (kind != BUS_RD);
    wr_n     = (kind != BUS_WR);
    in_n     = (kind != BUS_IN);
    out_n    = (kind != BUS_OUT);
  endtask

  task bus_hold(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (!trs_oe)
        oe_min = 1'b0;
    end
  endtask

  task bus_end;
    rd_n  = 1'b1;
    wr_n  = 1'b1;
    in_n  = 1'b1;
    out_n = 1'b1;
    repeat (6) @(negedge clk);  // strobe sync sees the idle bus
  endtask

  task bus_write(input logic [15:0] addr, input logic [7:0] data);
    bus_start(BUS_WR, addr, data);
    bus_hold(16);
    bus_end();
  endtask

  task wait_d_out(input logic [7:0] exp);
    int n;
    n = 0;
    while (trs_d_out !== exp && n < 20) begin
      @(negedge clk);
      if (!trs_oe)
        oe_min = 1'b0;
      n++;
    end
    check_val("trs_d_out", exp, trs_d_out);
  endtask

  task await_req;
    int n;
    n = 0;
    while (!esp_req && n < 30) begin
      @(negedge clk);
      n++;
    end
    if (!esp_req)
      report_timeout("esp_req to rise");
  endtask

  task await_wait_release;
    int n;
    n = 0;
    while (esp_wait && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (esp_wait)
      report_timeout("esp_wait to fall after esp_done");
  endtask

  // spi master, mode 0, 8 clocks per half period
  task spi_begin;
    cs_n = 1'b0;
    repeat (8) @(negedge clk);
  endtask

  task spi_end;
    repeat (8) @(negedge clk);
    cs_n = 1'b1;
    repeat (8) @(negedge clk);
  endtask

  task spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    int i;
    for (i = 7; i >= 0; i--) begin
      mosi = tx[i];
      repeat (8) @(negedge clk);
      rx[i] = miso;   // slave shifted on the last fall
      sck   = 1'b1;
      repeat (8) @(negedge clk);
      sck   = 1'b0;
    end
  endtask

  task spi_query(input logic [7:0] code, output logic [7:0] resp);
    logic [7:0] junk;
    spi_begin();
    spi_byte(code, junk);
    spi_byte(8'h00, resp);  // reply comes on the next byte
    spi_end();
  endtask

  task spi_param(input logic [7:0] code, input logic [7:0] p);
    logic [7:0] junk;
    spi_begin();
    spi_byte(code, junk);
    spi_byte(p, junk);
    spi_end();
  endtask

  task spi_poke(input logic [15:0] addr, input logic [7:0] data);
    logic [7:0] junk;
    spi_begin();
    spi_byte(trs_io_pkg::ram_poke, junk);
    spi_byte(addr[7:0], junk);
    spi_byte(addr[15:8], junk);
    spi_byte(data, junk);
    spi_end();
  endtask

  task spi_peek(input logic [15:0] addr, output logic [7:0] resp);
    logic [7:0] junk;
    spi_begin();
    spi_byte(trs_io_pkg::ram_peek, junk);
    spi_byte(addr[7:0], junk);
    spi_byte(addr[15:8], junk);
    spi_byte(8'h00, resp);
    spi_end();
  endtask

  a_miso_quiet: assert property (@(posedge clk) disable iff (reset)
    (cs_n && $past(cs_n) && $past(cs_n, 2)) |-> !miso)
    else begin
      errors++;
      $display("error miso expected 0x0 got 0x%0h while cs_n high", miso);
    end

  a_dir_toward_z80: assert property (@(posedge clk) disable iff (reset)
    (!rd_n || !in_n) |-> !trs_dir)
    else begin
      errors++;
      $display("error trs_dir expected 0x0 got 0x%0h during a read", trs_dir);
    end

  a_wait_with_req: assert property (@(posedge clk) disable iff (reset)
    $rose(esp_req) |-> esp_wait)
    else begin
      errors++;
      $display("error esp_wait expected 0x1 got 0x%0h as esp_req rose", esp_wait);
    end

  initial begin
    logic [31:0] rnd;
    logic [15:0] a;
    logic [7:0]  d;
    logic [7:0]  d_inv;
    logic [7:0]  r;
    int          n;

    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    lcg_state = 32'h57d4_c614;
    reset     = 1'b1;
    sck       = 1'b0;
    mosi      = 1'b0;
    cs_n      = 1'b1;
    trs_d_in  = 8'h00;
    rd_n      = 1'b1;
    wr_n      = 1'b1;
    in_n      = 1'b1;
    out_n     = 1'b1;
    esp_done  = 1'b0;
    bus_addr  = 16'h0000;
    oe_min    = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // idle outputs, cookie and version
    check_val("esp_req", 0, esp_req);
    check_val("esp_wait", 0, esp_wait);
    check_val("miso", 0, miso);
    check_val("trs_oe", 1, trs_oe);
    check_val("mux_a", 2'b10, mux_a);  // low byte while no access runs
    spi_query(trs_io_pkg::get_cookie, r);
    check_val("miso", `COOKIE, r);
    spi_query(trs_io_pkg::get_version, r);
    check_val("miso", {`VERSION_MAJOR, `VERSION_MINOR}, r);

    // poke then bus read, upper 32k
    rnd = next_random();
    a   = {1'b1, rnd[14:0]};
    d   = rnd[23:16];
    spi_poke(a, d);
    bus_start(BUS_RD, a, 8'h00);
    wait_d_out(d);
    bus_hold(4);
    check_val("trs_oe", 0, oe_min);
    bus_end();

    // bus write then peek
    rnd = next_random();
    a   = {1'b1, rnd[14:0]};
    d   = rnd[23:16];
    bus_write(a, d);
    spi_peek(a, r);
    check_val("miso", d, r);

    // 0x4000 only decodes in full address mode
    rnd   = next_random();
    d     = rnd[7:0];
    d_inv = ~d;
    spi_poke(16'h4000, d);
    bus_write(16'h4000, d_inv);
    check_val("trs_oe", 1, oe_min);
    spi_peek(16'h4000, r);
    check_val("miso", d, r);
    spi_param(trs_io_pkg::set_full_addr, 8'h01);
    bus_write(16'h4000, d_inv);
    check_val("trs_oe", 0, oe_min);
    spi_peek(16'h4000, r);
    check_val("miso", d_inv, r);

    // out to port 31, z80 parked on wait
    rnd = next_random();
    d   = rnd[15:8];
    bus_start(BUS_OUT, {8'h00, `TRS_IO_PORT}, d);
    await_req();
    check_val("esp_s", trs_io_pkg::trs_io_out, esp_s);
    check_val("esp_wait", 1, esp_wait);
    n = 0;
    while (esp_req && n < 2 * `ESP_REQ_CYCLES) begin
      n++;
      @(negedge clk);
    end
    check_val("esp_req_len", `ESP_REQ_CYCLES, n);
    spi_query(trs_io_pkg::dbus_read, r);
    check_val("miso", d, r);  // out byte still on the bus
    check_val("esp_wait", 1, esp_wait);
    check_val("trs_oe", 0, trs_oe);
    esp_done = 1'b1;
    await_wait_release();
    esp_done = 1'b0;
    bus_end();

    // coprocessor answer for an in from port 31
    rnd = next_random();
    d   = rnd[31:24];
    spi_param(trs_io_pkg::dbus_write, d);
    bus_start(BUS_IN, {8'h00, `TRS_IO_PORT}, 8'h00);
    await_req();
    check_val("esp_s", trs_io_pkg::trs_io_in, esp_s);
    check_val("trs_dir", 0, trs_dir);
    check_val("trs_d_out", d, trs_d_out);
    esp_done = 1'b1;
    await_wait_release();
    esp_done = 1'b0;
    bus_end();

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* trs_io_bridge.f */
+incdir+hw
hw/trs_io_pkg.sv
hw/trs_io_ifs.sv
hw/trs_bus_decoder.sv
hw/spi_cmd_port.sv
hw/trs_data_path.sv
hw/trs_io_bridge.sv
tests/trs_io_bridge_tb.sv
